/* src/tx_sched_defs.svh */
// QUEUE_COUNT must equal 2**QUEUE_INDEX_WIDTH; values are bare integers for use in ranges
`ifndef TX_SCHED_DEFS_SVH
`define TX_SCHED_DEFS_SVH

// Queue space
`define QUEUE_COUNT 4
`define QUEUE_INDEX_WIDTH 2

// Transmit engine status and request fields
`define LEN_WIDTH 16
`define DEST_WIDTH 8

// Per-queue pending doorbells, saturates at all ones
`define PEND_WIDTH 4

// Control register port
`define REG_ADDR_WIDTH 8
`define REG_DATA_WIDTH 32

`endif

/* src/tx_sched_pkg.sv */
// Tag is the queue index, so at most one request per queue may be outstanding downstream
`include "tx_sched_defs.svh"

package tx_sched_pkg;

    typedef struct packed {
        logic [`QUEUE_INDEX_WIDTH-1:0] queue;
        logic [`QUEUE_INDEX_WIDTH-1:0] tag;   // Same as queue
        logic [`DEST_WIDTH-1:0]        dest;
    } tx_req_t;

    typedef struct packed {
        logic [`LEN_WIDTH-1:0]         len;   // Zero means queue was empty
        logic [`QUEUE_INDEX_WIDTH-1:0] tag;
    } tx_status_t;

    typedef struct packed {
        logic [`QUEUE_INDEX_WIDTH-1:0] queue;
    } doorbell_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_SCAN, ARB_OFFER} arb_state_e;

    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        REG_TYPE     = 'h00,
        REG_VERSION  = 'h04,
        REG_CHANNELS = 'h08,
        REG_CTRL     = 'h10,
        REG_DEST     = 'h14
    } reg_addr_e;

endpackage

/* src/sched_ctrl_regs.sv */
// Master must hold en, address and data until ack; unknown addresses never ack
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module sched_ctrl_regs
    import tx_sched_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_wr_addr,
    input  logic [`REG_DATA_WIDTH-1:0] reg_wr_data,
    input  logic                       reg_wr_en,
    output logic                       reg_wr_ack,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_rd_addr,
    input  logic                       reg_rd_en,
    output logic [`REG_DATA_WIDTH-1:0] reg_rd_data,
    output logic                       reg_rd_ack,
    output logic                       enable,
    output logic [`DEST_WIDTH-1:0]     dest
);

    logic                       wr_hit;
    logic                       rd_hit;
    logic [`REG_DATA_WIDTH-1:0] rd_value;

    // Read-only offsets still ack a write
    always_comb begin
        case (reg_wr_addr)
            REG_TYPE, REG_VERSION, REG_CHANNELS, REG_CTRL, REG_DEST: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    always_comb begin
        rd_hit = 1'b1;
        rd_value = '0;
        case (reg_rd_addr)
            REG_TYPE:     rd_value = 32'h0000C040;   // Round-robin scheduler
            REG_VERSION:  rd_value = 32'h00000100;
            REG_CHANNELS: rd_value = `QUEUE_COUNT;
            REG_CTRL:     rd_value[0] = enable;
            REG_DEST:     rd_value[`DEST_WIDTH-1:0] = dest;
            default:      rd_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_wr_ack <= 1'b0;
            reg_rd_ack <= 1'b0;
            enable <= 1'b0;
            dest <= '0;
        end else begin
            reg_wr_ack <= reg_wr_en && !reg_wr_ack && wr_hit;
            reg_rd_ack <= reg_rd_en && !reg_rd_ack && rd_hit;
            if (reg_wr_en && !reg_wr_ack) begin
                if (reg_wr_addr == REG_CTRL) enable <= reg_wr_data[0];
                if (reg_wr_addr == REG_DEST) dest <= reg_wr_data[`DEST_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en && !reg_rd_ack) begin
            reg_rd_data <= rd_value;
        end
    end

    // Master drops en right after ack, so acks stay single pulses
    assert property (@(posedge clk) disable iff (rst) reg_wr_ack |=> !reg_wr_ack);
    assert property (@(posedge clk) disable iff (rst) reg_rd_ack |=> !reg_rd_ack);

endmodule

/* src/doorbell_decode.sv */
// One doorbell and one status per cycle at most; both inputs have no back-pressure
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module doorbell_decode
    import tx_sched_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  doorbell_t               doorbell,
    input  logic                    doorbell_valid,
    input  tx_status_t              tx_status,
    input  logic                    tx_status_valid,
    output logic [`QUEUE_COUNT-1:0] slot_inc,
    output logic [`QUEUE_COUNT-1:0] slot_done,
    output logic                    done_empty
);

    logic [`QUEUE_COUNT-1:0] inc_onehot;
    logic [`QUEUE_COUNT-1:0] done_onehot;

    always_comb begin
        inc_onehot = '0;
        done_onehot = '0;
        inc_onehot[doorbell.queue] = doorbell_valid;
        done_onehot[tx_status.tag] = tx_status_valid;   // Tag is the queue index
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_inc <= '0;
            slot_done <= '0;
            done_empty <= 1'b0;
        end else begin
            slot_inc <= inc_onehot;
            slot_done <= done_onehot;
            done_empty <= tx_status_valid && (tx_status.len == '0);
        end
    end

endmodule

/* src/queue_slot.sv */
// Pending count saturates at 15, so doorbells beyond that are lost until the queue drains
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module queue_slot #(
    parameter int SLOT_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`QUEUE_COUNT-1:0] slot_inc,
    input  logic [`QUEUE_COUNT-1:0] slot_done,
    input  logic                    done_empty,
    input  logic [`QUEUE_COUNT-1:0] slot_grant,
    output logic                    slot_ready
);

    logic                   inc;
    logic                   done;
    logic                   grant;
    logic [`PEND_WIDTH-1:0] pend_count;
    logic                   in_flight;

    assign inc = slot_inc[SLOT_INDEX];
    assign done = slot_done[SLOT_INDEX];
    assign grant = slot_grant[SLOT_INDEX];

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_count <= '0;
            in_flight <= 1'b0;
        end else begin
            if (done) begin
                in_flight <= 1'b0;
            end else if (grant) begin
                in_flight <= 1'b1;   // Set at the request transfer
            end

            if (done && done_empty) begin
                // Engine found the queue empty, keep only a doorbell landing now
                pend_count <= inc ? `PEND_WIDTH'(1) : '0;
            end else if (done && !inc) begin
                if (pend_count != '0) pend_count <= pend_count - 1'b1;
            end else if (inc && !done) begin
                if (pend_count != '1) pend_count <= pend_count + 1'b1;
            end
        end
    end

    assign slot_ready = (pend_count != '0) && !in_flight;

    // Status only for a queue with a request outstanding
    assert property (@(posedge clk) disable iff (rst) done |-> in_flight);

endmodule

/* src/rr_req_arbiter.sv */
// Grant is combinational on the transfer; scan resumes after the last granted queue
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module rr_req_arbiter
    import tx_sched_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  logic [`DEST_WIDTH-1:0]  dest,
    input  logic [`QUEUE_COUNT-1:0] slot_ready,
    output logic [`QUEUE_COUNT-1:0] slot_grant,
    output tx_req_t                 tx_req,
    output logic                    tx_req_valid,
    input  logic                    tx_req_ready
);

    localparam int QC = `QUEUE_COUNT;
    localparam int QIW = `QUEUE_INDEX_WIDTH;

    arb_state_e     state;
    logic [QIW-1:0] last_grant;
    logic [QIW-1:0] cand_index;
    logic [QIW-1:0] pick_index;
    logic           pick_found;

    // First ready slot after last_grant, wrapping
    always_comb begin
        pick_found = 1'b0;
        pick_index = last_grant;
        cand_index = last_grant;
        for (int i = 1; i <= QC; i++) begin
            cand_index = QIW'((int'(last_grant) + i) % QC);
            if (!pick_found && slot_ready[cand_index]) begin
                pick_found = 1'b1;
                pick_index = cand_index;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            tx_req_valid <= 1'b0;
            last_grant <= QIW'(QC - 1);   // Queue 0 goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (enable) state <= ARB_SCAN;
                end
                ARB_SCAN: begin
                    if (!enable) begin
                        state <= ARB_IDLE;
                    end else if (pick_found) begin
                        tx_req_valid <= 1'b1;
                        state <= ARB_OFFER;
                    end
                end
                ARB_OFFER: begin
                    // An offer made runs to completion even if enable drops
                    if (tx_req_ready) begin
                        tx_req_valid <= 1'b0;
                        last_grant <= tx_req.queue;
                        state <= enable ? ARB_SCAN : ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_SCAN && enable && pick_found) begin
            tx_req <= '{queue: pick_index, tag: pick_index, dest: dest};
        end
    end

    always_comb begin
        slot_grant = '0;
        if (tx_req_valid && tx_req_ready) slot_grant[tx_req.queue] = 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst)
        (tx_req_valid && !tx_req_ready) |=> (tx_req_valid && $stable(tx_req)));

endmodule

/* src/tx_scheduler_block.sv */
// Doorbell to request takes several cycles; engine must return one status per request issued
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module tx_scheduler_block
    import tx_sched_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_wr_addr,
    input  logic [`REG_DATA_WIDTH-1:0] reg_wr_data,
    input  logic                       reg_wr_en,
    output logic                       reg_wr_ack,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_rd_addr,
    input  logic                       reg_rd_en,
    output logic [`REG_DATA_WIDTH-1:0] reg_rd_data,
    output logic                       reg_rd_ack,
    input  doorbell_t                  doorbell,
    input  logic                       doorbell_valid,
    output tx_req_t                    tx_req,
    output logic                       tx_req_valid,
    input  logic                       tx_req_ready,
    input  tx_status_t                 tx_status,
    input  logic                       tx_status_valid
);

    logic                    enable;
    logic [`DEST_WIDTH-1:0]  dest;
    logic [`QUEUE_COUNT-1:0] slot_inc;
    logic [`QUEUE_COUNT-1:0] slot_done;
    logic                    done_empty;
    logic [`QUEUE_COUNT-1:0] slot_ready;
    logic [`QUEUE_COUNT-1:0] slot_grant;

    sched_ctrl_regs u_regs (
        .clk(clk), .rst(rst),
        .reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
        .reg_wr_en(reg_wr_en), .reg_wr_ack(reg_wr_ack),
        .reg_rd_addr(reg_rd_addr), .reg_rd_en(reg_rd_en),
        .reg_rd_data(reg_rd_data), .reg_rd_ack(reg_rd_ack),
        .enable(enable), .dest(dest)
    );

    doorbell_decode u_decode (
        .clk(clk), .rst(rst),
        .doorbell(doorbell), .doorbell_valid(doorbell_valid),
        .tx_status(tx_status), .tx_status_valid(tx_status_valid),
        .slot_inc(slot_inc), .slot_done(slot_done), .done_empty(done_empty)
    );

    for (genvar i = 0; i < `QUEUE_COUNT; i++) begin : g_slot
        queue_slot #(.SLOT_INDEX(i)) u_slot (
            .clk(clk), .rst(rst),
            .slot_inc(slot_inc), .slot_done(slot_done), .done_empty(done_empty),
            .slot_grant(slot_grant), .slot_ready(slot_ready[i])
        );
    end

    rr_req_arbiter u_arb (
        .clk(clk), .rst(rst),
        .enable(enable), .dest(dest),
        .slot_ready(slot_ready), .slot_grant(slot_grant),
        .tx_req(tx_req), .tx_req_valid(tx_req_valid), .tx_req_ready(tx_req_ready)
    );

endmodule

/* bench/clk_gen.sv */
// Clock runs from time zero; reset drops 1 ns after the last reset edge, in step with stimulus
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* bench/tb_tx_scheduler.sv */
// Assumes 4 queues and an engine model that accepts each request and returns its status at once
`timescale 1ns/1ns
`include "tx_sched_defs.svh"

module tb_tx_scheduler
    import tx_sched_pkg::*;
();

    localparam int WATCHDOG_NS = 20000;   // Normal run takes a few hundred cycles

    logic                       clk;
    logic                       rst;
    logic [`REG_ADDR_WIDTH-1:0] reg_wr_addr;
    logic [`REG_DATA_WIDTH-1:0] reg_wr_data;
    logic                       reg_wr_en;
    logic                       reg_wr_ack;
    logic [`REG_ADDR_WIDTH-1:0] reg_rd_addr;
    logic                       reg_rd_en;
    logic [`REG_DATA_WIDTH-1:0] reg_rd_data;
    logic                       reg_rd_ack;
    doorbell_t                  doorbell;
    logic                       doorbell_valid;
    tx_req_t                    tx_req;
    logic                       tx_req_valid;
    logic                       tx_req_ready;
    tx_status_t                 tx_status;
    logic                       tx_status_valid;

    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] rng_state = 32'hba71;
    logic [1:0]  last_q = 2'd3;   // Queue 0 is first after reset
    logic [7:0]  cur_dest = 8'h00;

    clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst(rst));

    tx_scheduler_block uut (.*);

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #1;   // Drive and sample point
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        reg_wr_addr = addr;
        reg_wr_data = data;
        reg_wr_en = 1'b1;
        n = 0;
        do begin
            wait_cycle();
            n++;
        end while (!reg_wr_ack && n < 8);
        reg_wr_en = 1'b0;
        if (!reg_wr_ack) report_failure($sformatf("write to 0x%02h got no ack", addr));
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output bit acked);
        int n;
        reg_rd_addr = addr;
        reg_rd_en = 1'b1;
        n = 0;
        do begin
            wait_cycle();
            n++;
        end while (!reg_rd_ack && n < 8);
        reg_rd_en = 1'b0;
        acked = reg_rd_ack;
        data = reg_rd_data;
    endtask

    task automatic read_and_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        bit          acked;
        reg_read(addr, data, acked);
        if (!acked) begin
            report_failure($sformatf("read of 0x%02h got no ack", addr));
        end else if (data !== expected) begin
            report_error($sformatf("read 0x%02h got %08h, expected %08h",
                addr, data, expected));
        end
    endtask

    task automatic ring(input logic [1:0] q);
        doorbell.queue = q;
        doorbell_valid = 1'b1;
        wait_cycle();
        doorbell_valid = 1'b0;
    endtask

    task automatic send_status(input logic [1:0] q, input logic [15:0] len);
        tx_status = '{len: len, tag: q};
        tx_status_valid = 1'b1;
        wait_cycle();
        tx_status_valid = 1'b0;
    endtask

    task automatic wait_for_valid(output bit found);
        int n;
        n = 0;
        while (!tx_req_valid && n < 30) begin
            wait_cycle();
            n++;
        end
        found = tx_req_valid;
    endtask

    // Checks the offered request, then accepts it for one cycle
    task automatic expect_req(input logic [1:0] q);
        bit found;
        wait_for_valid(found);
        if (!found) begin
            report_failure($sformatf("no request for queue %0d within 30 cycles", q));
            return;
        end
        if (tx_req.queue !== q || tx_req.tag !== q || tx_req.dest !== cur_dest) begin
            report_error($sformatf("request q=%0d tag=%0d dest=%02h, expected q=%0d dest=%02h",
                tx_req.queue, tx_req.tag, tx_req.dest, q, cur_dest));
        end
        tx_req_ready = 1'b1;
        wait_cycle();
        tx_req_ready = 1'b0;
        last_q = q;
    endtask

    task automatic expect_none(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            if (tx_req_valid) begin
                report_failure($sformatf("unexpected request for queue %0d", tx_req.queue));
                break;
            end
            wait_cycle();
        end
    endtask

    task automatic registers_and_control();
        int          errs;
        logic [31:0] data;
        bit          acked;
        errs = err_count;
        read_and_check(REG_TYPE, 32'h0000C040);
        read_and_check(REG_VERSION, 32'h00000100);
        read_and_check(REG_CHANNELS, 32'd4);
        read_and_check(REG_CTRL, 32'd0);
        read_and_check(REG_DEST, 32'd0);
        reg_write(REG_CTRL, 32'd1);
        reg_write(REG_DEST, 32'h000000A5);
        reg_write(REG_TYPE, 32'hFFFFFFFF);   // Read-only register keeps its value
        read_and_check(REG_CTRL, 32'd1);
        read_and_check(REG_DEST, 32'h000000A5);
        read_and_check(REG_TYPE, 32'h0000C040);
        reg_read(8'h20, data, acked);
        if (acked) report_failure("read of unknown offset 0x20 was acknowledged");
        reg_write(REG_CTRL, 32'd0);
        finish_test("registers", errs);
    endtask

    task automatic disabled_gating();
        int errs;
        errs = err_count;
        reg_write(REG_DEST, 32'h0000003C);
        cur_dest = 8'h3C;
        ring(2'd2);
        expect_none(20);
        reg_write(REG_CTRL, 32'd1);
        expect_req(2'd2);
        send_status(2'd2, 16'd64);
        finish_test("disabled", errs);
    endtask

    task automatic round_robin_order();
        int errs;
        errs = err_count;
        reg_write(REG_CTRL, 32'd0);
        for (int q = 0; q < 4; q++) ring(2'(q));
        reg_write(REG_CTRL, 32'd1);
        for (int i = 0; i < 4; i++) begin
            expect_req(last_q + 2'd1);
            send_status(last_q, 16'(100 + i));
        end
        expect_none(20);
        finish_test("round_robin", errs);
    endtask

    task automatic pending_count_drain();
        int errs;
        int n;
        errs = err_count;
        n = 1 + int'(next_random() % 5);
        for (int i = 0; i < n; i++) ring(2'd1);
        for (int i = 0; i < n; i++) begin
            expect_req(2'd1);
            send_status(2'd1, 16'(1 + next_random() % 1500));
        end
        expect_none(20);
        repeat (3) ring(2'd3);
        expect_req(2'd3);
        send_status(2'd3, 16'd0);   // Engine found the queue empty
        expect_none(20);
        finish_test($sformatf("pending_counts n=%0d", n), errs);
    endtask

    task automatic backpressure_hold();
        int      errs;
        int      hold;
        bit      found;
        tx_req_t expected;
        errs = err_count;
        expected = '{queue: 2'd0, tag: 2'd0, dest: cur_dest};
        repeat (3) ring(2'd0);
        wait_for_valid(found);
        if (!found) report_failure("no request for queue 0 within 30 cycles");
        if (tx_req !== expected) begin
            report_error($sformatf("request q=%0d tag=%0d dest=%02h, expected q=0 dest=%02h",
                tx_req.queue, tx_req.tag, tx_req.dest, cur_dest));
        end
        hold = 2 + int'(next_random() % 8);
        repeat (hold) begin
            wait_cycle();
            if (!tx_req_valid || tx_req !== expected) begin
                report_error("request dropped or changed while stalled");
            end
        end
        tx_req_ready = 1'b1;
        wait_cycle();
        tx_req_ready = 1'b0;
        last_q = 2'd0;
        expect_none(20);   // Queue 0 still pending but in flight
        for (int i = 0; i < 2; i++) begin
            send_status(2'd0, 16'd60);
            expect_req(2'd0);
        end
        send_status(2'd0, 16'd60);
        expect_none(20);
        finish_test($sformatf("backpressure hold=%0d", hold), errs);
    endtask

    initial begin : main
        reg_wr_addr = '0;
        reg_wr_data = '0;
        reg_wr_en = 1'b0;
        reg_rd_addr = '0;
        reg_rd_en = 1'b0;
        doorbell = '0;
        doorbell_valid = 1'b0;
        tx_req_ready = 1'b0;
        tx_status = '0;
        tx_status_valid = 1'b0;
        wait (rst == 1'b0);
        wait_cycle();
        registers_and_control();
        disabled_gating();
        round_robin_order();
        pending_count_drain();
        backpressure_hold();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/tx_sched_pkg.sv
src/sched_ctrl_regs.sv
src/doorbell_decode.sv
src/queue_slot.sv
src/rr_req_arbiter.sv
src/tx_scheduler_block.sv
bench/clk_gen.sv
bench/tb_tx_scheduler.sv

/* run_sim.sh */
#!/bin/bash
# Builds the testbench with Verilator and runs it; exit status 0 only on a passing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_tx_scheduler -f verilog.f -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
